/* ls_stage.f */
+incdir+.
ls_stage_pkg.sv
ls_ctrl.sv
lsu.sv
csr_unit.sv
mem_arbiter.sv
data_ram.sv
ls_stage_top.sv
ls_stage_assertions.sv
tb_ls_stage.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f ls_stage.f --top-module tb_ls_stage \
		-Mdir obj_dir -o sim_ls_stage
	@out="$$(./obj_dir/sim_ls_stage)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* tb_ls_stage.sv */
`timescale 1ns/1ps
`include "ls_stage_macros.svh"

module tb_ls_stage;

    // reset, host fill and readback, then the pipeline tests
    localparam int TEST_CYCLES = 10 + 1 + 3 * 256 + 3 * 15 + 30 + 4 * 3 + 4 * 4 + 3 + 3;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic                   clk;
    logic                   reset_i;
    logic [`XLEN-1:0]       pc_i;
    logic [`XLEN-1:0]       alures_i;
    logic [`XLEN-1:0]       rs2_i;
    logic [`XLEN-1:0]       wb_data_i;
    ls_stage_pkg::instr_u   instr_i;
    logic                   trap_i;
    ls_stage_pkg::mem_req_t host_req_i;
    logic [`XLEN-1:0]       ls_res_o;
    logic [`XLEN-1:0]       csr_data_o;
    logic [`XLEN-1:0]       mtvec_o;
    logic [`XLEN-1:0]       mepc_o;
    logic                   load_valid_o;
    logic                   host_stall_o;
    logic                   host_rvalid_o;
    ls_stage_pkg::mem_rsp_t host_rsp_o;

    logic [`XLEN-1:0] mem_model [0:`RAM_DEPTH-1];
    int               error_count = 0;
    int               tests_run = 0;
    int               tests_failed = 0;
    int               cycle_count = 0;
    int               assert_fails;

    ls_stage_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_data(logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp, string what);
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_rsp(ls_stage_pkg::mem_rsp_t got, ls_stage_pkg::mem_rsp_t exp,
                             string what);
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got.rdata,
                     exp.rdata);
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(string name, int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errs_before);
        end
    endtask

    function automatic ls_stage_pkg::instr_u load_instr(logic [4:0] rd, logic [2:0] f3);
        ls_stage_pkg::instr_u w;
        w = '0;
        w.i.opcode = {`OP_LOAD, 2'b11};
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.rs1    = 5'd1;
        return w;
    endfunction

    function automatic ls_stage_pkg::instr_u store_instr(logic [4:0] rs2, logic [2:0] f3);
        ls_stage_pkg::instr_u w;
        w = '0;
        w.s.opcode = {`OP_STORE, 2'b11};
        w.s.funct3 = f3;
        w.s.rs2    = rs2;
        w.s.rs1    = 5'd1;
        return w;
    endfunction

    function automatic ls_stage_pkg::instr_u csr_instr(logic [2:0] f3, logic [11:0] addr);
        ls_stage_pkg::instr_u w;
        w = '0;
        w.i.opcode = {`OP_SYSTEM, 2'b11};
        w.i.funct3 = f3;
        w.i.imm    = addr;
        w.i.rd     = 5'd3;
        return w;
    endfunction

    // bytes off..off+size-1 of the word, then sign or zero fill
    function automatic logic [`XLEN-1:0] expected_load(logic [`XLEN-1:0] word,
                                                       logic [2:0] off, logic [2:0] f3);
        int               size;
        logic             sign;
        logic [`XLEN-1:0] v;
        size = 1 << f3[1:0];
        v = '0;
        for (int b = 0; b < size; b++) begin
            v[b*8 +: 8] = word[(off + b) * 8 +: 8];
        end
        sign = v[size*8-1];
        if (!f3[2] && sign) begin
            for (int b = size; b < 8; b++) begin
                v[b*8 +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    function automatic void model_store(int w, logic [2:0] off, logic [2:0] f3,
                                        logic [`XLEN-1:0] data);
        int size;
        size = 1 << f3[1:0];
        for (int b = 0; b < size; b++) begin
            mem_model[w][(off + b) * 8 +: 8] = data[b*8 +: 8];
        end
    endfunction

    task automatic host_write(int w, logic [`XLEN-1:0] data);
        @(posedge clk);
        host_req_i <= '{en: 1'b1, we: 1'b1, addr: 8'(w), wdata: data, mask: 8'hff};
        mem_model[w] = data;
        @(negedge clk);
        check_flag(host_stall_o, 1'b0, "host write stalled");
    endtask

    // pipeline goes idle so the host owns the port
    task automatic host_read(int w);
        ls_stage_pkg::mem_rsp_t exp;
        @(posedge clk);
        instr_i    <= '0;
        host_req_i <= '{en: 1'b1, we: 1'b0, addr: 8'(w), wdata: 64'h0, mask: 8'h00};
        @(negedge clk);
        check_flag(host_stall_o, 1'b0, "host read stalled");
        @(posedge clk);
        host_req_i <= '0;
        @(negedge clk);
        exp.rdata = mem_model[w];
        check_flag(host_rvalid_o, 1'b1, "host_rvalid_o after read");
        check_rsp(host_rsp_o, exp, $sformatf("host read of word %0d", w));
    endtask

    task automatic host_access();
        int errs;
        errs = error_count;
        @(negedge clk);
        check_flag(load_valid_o, 1'b0, "load_valid_o after reset");
        check_flag(host_stall_o, 1'b0, "host_stall_o after reset");
        check_flag(host_rvalid_o, 1'b0, "host_rvalid_o after reset");
        for (int w = 0; w < `RAM_DEPTH; w++) begin
            host_write(w, {$urandom, $urandom});
        end
        for (int w = 0; w < `RAM_DEPTH; w++) begin
            host_read(w);
        end
        report_test("host access", errs);
    endtask

    task automatic store_masks();
        int               errs;
        int               w;
        int               size;
        logic [`XLEN-1:0] data;
        errs = error_count;
        w = 16;
        for (int k = 0; k < 4; k++) begin
            size = 1 << k;
            for (int off = 0; off < 8; off += size) begin
                data = {$urandom, $urandom};
                @(posedge clk);
                instr_i   <= store_instr(5'd2, 3'(k));
                alures_i  <= 64'(w * 8 + off);
                rs2_i     <= data;
                wb_data_i <= ~data;
                model_store(w, 3'(off), 3'(k), data);
                host_read(w);
                w++;
            end
        end
        report_test("store masks", errs);
    endtask

    // one load per cycle, each result checked while the next load issues
    task automatic load_extension();
        int               errs;
        int               size;
        logic             pend;
        logic [`XLEN-1:0] exp;
        errs = error_count;
        pend = 1'b0;
        for (int k = 0; k < 7; k++) begin
            size = 1 << k[1:0];
            for (int off = 0; off < 8; off += size) begin
                @(posedge clk);
                instr_i  <= load_instr(5'd5, 3'(k));
                alures_i <= 64'((40 + k) * 8 + off);
                @(negedge clk);
                if (pend) begin
                    check_flag(load_valid_o, 1'b1, "load_valid_o");
                    check_data(ls_res_o, exp, "back-to-back load result");
                end
                exp  = expected_load(mem_model[40 + k], 3'(off), 3'(k));
                pend = 1'b1;
            end
        end
        @(posedge clk);
        instr_i <= '0;
        @(negedge clk);
        check_flag(load_valid_o, 1'b1, "load_valid_o on last load");
        check_data(ls_res_o, exp, "last load result");
        report_test("load extension", errs);
    endtask

    task automatic store_forwarding();
        int               errs;
        logic [4:0]       ld_rd [3];
        logic [4:0]       st_rs2 [3];
        logic [`XLEN-1:0] r2;
        logic [`XLEN-1:0] wb;
        errs = error_count;
        ld_rd  = '{5'd7, 5'd0, 5'd7};
        st_rs2 = '{5'd7, 5'd0, 5'd9};
        for (int t = 0; t < 3; t++) begin
            r2 = {$urandom, $urandom};
            wb = {$urandom, $urandom};
            @(posedge clk);
            instr_i  <= load_instr(ld_rd[t], `F3_D);
            alures_i <= 64'(40 * 8);
            @(posedge clk);
            instr_i   <= store_instr(st_rs2[t], `F3_D);
            alures_i  <= 64'((50 + t) * 8);
            rs2_i     <= r2;
            wb_data_i <= wb;
            // forward only from a load into a matching nonzero rs2
            if (ld_rd[t] == st_rs2[t] && ld_rd[t] != 5'd0) begin
                model_store(50 + t, 3'd0, `F3_D, wb);
            end else begin
                model_store(50 + t, 3'd0, `F3_D, r2);
            end
            host_read(50 + t);
        end
        report_test("store forwarding", errs);
    endtask

    task automatic csr_and_trap();
        int               errs;
        logic [11:0]      addrs [4];
        logic [`XLEN-1:0] csr_model [4];
        logic [`XLEN-1:0] opnd;
        logic [`XLEN-1:0] pc;
        errs = error_count;
        addrs     = '{`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE};
        csr_model = '{64'h0, `MTVEC_RESET, 64'h0, 64'h0};
        for (int c = 0; c < 4; c++) begin
            for (int op = 1; op < 4; op++) begin
                opnd = {$urandom, $urandom};
                @(posedge clk);
                instr_i  <= csr_instr(3'(op), addrs[c]);
                alures_i <= opnd;
                @(negedge clk);
                check_data(csr_data_o, csr_model[c], $sformatf("old value of csr %h", addrs[c]));
                check_data(mtvec_o, csr_model[1], "mtvec_o");
                check_data(mepc_o, csr_model[2], "mepc_o");
                case (3'(op))
                    `F3_CSRRW: csr_model[c] = opnd;
                    `F3_CSRRS: csr_model[c] = csr_model[c] | opnd;
                    default:   csr_model[c] = csr_model[c] & ~opnd;
                endcase
            end
            // set with a zero operand reads back the csrrc result
            @(posedge clk);
            instr_i  <= csr_instr(`F3_CSRRS, addrs[c]);
            alures_i <= '0;
            @(negedge clk);
            check_data(csr_data_o, csr_model[c], $sformatf("csrrc result of csr %h", addrs[c]));
        end
        // mepc write in the trap cycle must lose
        pc = {$urandom, $urandom};
        @(posedge clk);
        instr_i  <= csr_instr(`F3_CSRRW, `CSR_MEPC);
        alures_i <= ~pc;
        pc_i     <= pc;
        trap_i   <= 1'b1;
        csr_model[2] = pc;
        csr_model[3] = 64'(`CAUSE_ECALL);
        @(posedge clk);
        trap_i   <= 1'b0;
        instr_i  <= csr_instr(`F3_CSRRS, `CSR_MCAUSE);
        alures_i <= '0;
        @(negedge clk);
        check_data(csr_data_o, csr_model[3], "mcause after trap");
        check_data(mepc_o, csr_model[2], "mepc_o after trap");
        check_data(mtvec_o, csr_model[1], "mtvec_o after trap");
        @(posedge clk);
        instr_i <= '0;
        report_test("csr and trap", errs);
    endtask

    task automatic arbitration();
        int                     errs;
        ls_stage_pkg::mem_rsp_t exp;
        errs = error_count;
        @(posedge clk);
        instr_i    <= load_instr(5'd5, `F3_D);
        alures_i   <= 64'(60 * 8);
        host_req_i <= '{en: 1'b1, we: 1'b0, addr: 8'd61, wdata: 64'h0, mask: 8'h00};
        @(negedge clk);
        check_flag(host_stall_o, 1'b1, "host_stall_o during lsu access");
        // host holds its request for the retry
        @(posedge clk);
        instr_i <= '0;
        @(negedge clk);
        check_flag(load_valid_o, 1'b1, "load_valid_o under contention");
        check_data(ls_res_o, mem_model[60], "load result under contention");
        check_flag(host_stall_o, 1'b0, "host_stall_o on retry");
        check_flag(host_rvalid_o, 1'b0, "host_rvalid_o after stalled read");
        @(posedge clk);
        host_req_i <= '0;
        @(negedge clk);
        exp.rdata = mem_model[61];
        check_flag(host_rvalid_o, 1'b1, "host_rvalid_o after retry");
        check_rsp(host_rsp_o, exp, "retried host read");
        report_test("arbitration", errs);
    endtask

    initial begin
        void'($urandom(32'h3004));
        reset_i    <= 1'b1;
        pc_i       <= '0;
        alures_i   <= '0;
        rs2_i      <= '0;
        wb_data_i  <= '0;
        instr_i    <= '0;
        trap_i     <= 1'b0;
        host_req_i <= '0;
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;
        host_access();
        store_masks();
        load_extension();
        store_forwarding();
        csr_and_trap();
        arbitration();
        assert_fails = uut.u_arb.u_arb_sva.fail_count + uut.u_lsu.u_lsu_sva.fail_count;
        $display("%0d tests run, %0d tests failed, %0d checks failed, %0d assertions failed",
                 tests_run, tests_failed, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* ls_stage_assertions.sv */
`timescale 1ns/1ps

module ls_stage_assertions (
    input logic clk,
    input logic reset_i,
    input logic lsu_en_i,
    input logic host_en_i,
    input logic host_we_i,
    input logic host_stall_i,
    input logic host_rvalid_i,
    input logic rden_i,
    input logic load_valid_i,
    input logic ram_en_i,
    input logic ram_we_i
);

    int fail_count = 0;

    // host only stalls while the lsu holds the ram port
    stall_needs_lsu: assert property (@(posedge clk) disable iff (reset_i)
        host_stall_i |-> lsu_en_i && ram_en_i)
        else begin
            fail_count++;
            $error("host stalled with no lsu access on the ram port");
        end

    // rvalid follows a host read that reached the ram
    rvalid_after_grant: assert property (@(posedge clk) disable iff (reset_i)
        host_rvalid_i |-> $past(host_en_i && !host_we_i && !lsu_en_i && ram_en_i && !ram_we_i))
        else begin
            fail_count++;
            $error("host_rvalid_o without a granted host read");
        end

    // load result one cycle after a read went out on the port
    load_valid_after_rden: assert property (@(posedge clk) disable iff (reset_i)
        load_valid_i |-> $past(rden_i && ram_en_i && !ram_we_i))
        else begin
            fail_count++;
            $error("load_valid_o without a load the cycle before");
        end

endmodule

// unused inputs of each binding are tied low
bind mem_arbiter ls_stage_assertions u_arb_sva (
    .clk           (clk),
    .reset_i       (reset_i),
    .lsu_en_i      (lsu_req_i.en),
    .host_en_i     (host_req_i.en),
    .host_we_i     (host_req_i.we),
    .host_stall_i  (host_stall_o),
    .host_rvalid_i (host_rvalid_o),
    .rden_i        (1'b0),
    .load_valid_i  (1'b0),
    .ram_en_i      (ram_req_o.en),
    .ram_we_i      (ram_req_o.we)
);

bind lsu ls_stage_assertions u_lsu_sva (
    .clk           (clk),
    .reset_i       (reset_i),
    .lsu_en_i      (mem_req_o.en),
    .host_en_i     (1'b0),
    .host_we_i     (1'b0),
    .host_stall_i  (1'b0),
    .host_rvalid_i (1'b0),
    .rden_i        (rden_i),
    .load_valid_i  (load_valid_o),
    .ram_en_i      (mem_req_o.en),
    .ram_we_i      (mem_req_o.we)
);

/* ls_stage_top.sv */
`timescale 1ns/1ps
`include "ls_stage_macros.svh"

module ls_stage_top (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  logic [`XLEN-1:0]       alures_i,
    input  logic [`XLEN-1:0]       rs2_i,
    input  logic [`XLEN-1:0]       wb_data_i,
    input  ls_stage_pkg::instr_u   instr_i,
    input  logic                   trap_i,
    input  ls_stage_pkg::mem_req_t host_req_i,
    output logic [`XLEN-1:0]       ls_res_o,
    output logic [`XLEN-1:0]       csr_data_o,
    output logic [`XLEN-1:0]       mtvec_o,
    output logic [`XLEN-1:0]       mepc_o,
    output logic                   load_valid_o,
    output logic                   host_stall_o,
    output logic                   host_rvalid_o,
    output ls_stage_pkg::mem_rsp_t host_rsp_o
);

    ls_stage_pkg::instr_u   instr_last_q;
    logic                   rden;
    logic                   wren;
    logic                   csr_en;
    logic [2:0]             memop;
    logic [1:0]             csr_op;
    logic [11:0]            csr_addr;
    logic [`XLEN-1:0]       st_data;
    ls_stage_pkg::mem_req_t lsu_req;
    ls_stage_pkg::mem_rsp_t lsu_rsp;
    ls_stage_pkg::mem_req_t ram_req;
    ls_stage_pkg::mem_rsp_t ram_rsp;

    // previous instruction, for the load-to-store forward
    always_ff @(posedge clk) begin
        if (reset_i) begin
            instr_last_q <= '0;
        end else begin
            instr_last_q <= instr_i;
        end
    end

    ls_ctrl u_ctrl (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_q),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .rden_o       (rden),
        .wren_o       (wren),
        .csr_en_o     (csr_en),
        .memop_o      (memop),
        .csr_op_o     (csr_op),
        .csr_addr_o   (csr_addr),
        .st_data_o    (st_data)
    );

    lsu u_lsu (
        .clk          (clk),
        .reset_i      (reset_i),
        .rden_i       (rden),
        .wren_i       (wren),
        .memop_i      (memop),
        .addr_i       (alures_i),
        .st_data_i    (st_data),
        .mem_rsp_i    (lsu_rsp),
        .mem_req_o    (lsu_req),
        .ls_res_o     (ls_res_o),
        .load_valid_o (load_valid_o)
    );

    // alu result carries the csr operand
    csr_unit u_csr (
        .clk          (clk),
        .reset_i      (reset_i),
        .csr_en_i     (csr_en),
        .csr_op_i     (csr_op),
        .csr_addr_i   (csr_addr),
        .csr_wdata_i  (alures_i),
        .pc_i         (pc_i),
        .trap_i       (trap_i),
        .csr_data_o   (csr_data_o),
        .mtvec_o      (mtvec_o),
        .mepc_o       (mepc_o)
    );

    mem_arbiter u_arb (
        .clk           (clk),
        .reset_i       (reset_i),
        .lsu_req_i     (lsu_req),
        .host_req_i    (host_req_i),
        .ram_rsp_i     (ram_rsp),
        .ram_req_o     (ram_req),
        .lsu_rsp_o     (lsu_rsp),
        .host_rsp_o    (host_rsp_o),
        .host_stall_o  (host_stall_o),
        .host_rvalid_o (host_rvalid_o)
    );

    data_ram u_ram (
        .clk   (clk),
        .req_i (ram_req),
        .rsp_o (ram_rsp)
    );

endmodule

/* data_ram.sv */
`timescale 1ns/1ps
`include "ls_stage_macros.svh"

module data_ram (
    input  logic                   clk,
    input  ls_stage_pkg::mem_req_t req_i,
    output ls_stage_pkg::mem_rsp_t rsp_o
);

    logic [`XLEN-1:0] mem [0:`RAM_DEPTH-1];
    logic [`XLEN-1:0] rdata_q;

    // byte-masked write
    always_ff @(posedge clk) begin
        if (req_i.en && req_i.we) begin
            for (int b = 0; b < 8; b++) begin
                if (req_i.mask[b]) begin
                    mem[req_i.addr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // registered read, output holds between reads
    always_ff @(posedge clk) begin
        if (req_i.en && !req_i.we) begin
            rdata_q <= mem[req_i.addr];
        end
    end

    assign rsp_o.rdata = rdata_q;

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                   clk,
    input  logic                   reset_i,
    input  ls_stage_pkg::mem_req_t lsu_req_i,
    input  ls_stage_pkg::mem_req_t host_req_i,
    input  ls_stage_pkg::mem_rsp_t ram_rsp_i,
    output ls_stage_pkg::mem_req_t ram_req_o,
    output ls_stage_pkg::mem_rsp_t lsu_rsp_o,
    output ls_stage_pkg::mem_rsp_t host_rsp_o,
    output logic                   host_stall_o,
    output logic                   host_rvalid_o
);

    logic host_grant;
    logic host_rd_q;

    // lsu has fixed priority, host only gets idle cycles
    assign host_grant   = host_req_i.en && !lsu_req_i.en;
    assign host_stall_o = lsu_req_i.en;

    assign ram_req_o = lsu_req_i.en ? lsu_req_i : host_req_i;

    // host read granted now, data valid next cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            host_rd_q <= 1'b0;
        end else begin
            host_rd_q <= host_grant && !host_req_i.we;
        end
    end

    // read data goes to both sides, each knows when it is theirs
    assign lsu_rsp_o     = ram_rsp_i;
    assign host_rsp_o    = ram_rsp_i;
    assign host_rvalid_o = host_rd_q;

endmodule

/* csr_unit.sv */
`timescale 1ns/1ps
`include "ls_stage_macros.svh"

module csr_unit (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             csr_en_i,
    input  logic [1:0]       csr_op_i,
    input  logic [11:0]      csr_addr_i,
    input  logic [`XLEN-1:0] csr_wdata_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic             trap_i,
    output logic [`XLEN-1:0] csr_data_o,
    output logic [`XLEN-1:0] mtvec_o,
    output logic [`XLEN-1:0] mepc_o
);

    logic [`XLEN-1:0] mstatus_q;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;
    logic [`XLEN-1:0] csr_old;
    logic [`XLEN-1:0] csr_new;

    // old value of the addressed csr, unknown addresses read zero
    always_comb begin
        case (csr_addr_i)
            `CSR_MSTATUS: csr_old = mstatus_q;
            `CSR_MTVEC:   csr_old = mtvec_q;
            `CSR_MEPC:    csr_old = mepc_q;
            `CSR_MCAUSE:  csr_old = mcause_q;
            default:      csr_old = '0;
        endcase
    end

    // read-modify-write
    always_comb begin
        case ({1'b0, csr_op_i})
            `F3_CSRRW: csr_new = csr_wdata_i;
            `F3_CSRRS: csr_new = csr_old | csr_wdata_i;
            `F3_CSRRC: csr_new = csr_old & ~csr_wdata_i;
            default:   csr_new = csr_old;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mstatus_q <= '0;
            mtvec_q   <= `MTVEC_RESET;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (trap_i) begin
            // trap wins over any csr write this cycle
            mepc_q   <= pc_i;
            mcause_q <= `XLEN'(`CAUSE_ECALL);
        end else if (csr_en_i) begin
            case (csr_addr_i)
                `CSR_MSTATUS: mstatus_q <= csr_new;
                `CSR_MTVEC:   mtvec_q   <= csr_new;
                `CSR_MEPC:    mepc_q    <= csr_new;
                `CSR_MCAUSE:  mcause_q  <= csr_new;
                default:      ;
            endcase
        end
    end

    assign csr_data_o = csr_old;
    assign mtvec_o    = mtvec_q;
    assign mepc_o     = mepc_q;

endmodule

/* lsu.sv */
`timescale 1ns/1ps
`include "ls_stage_macros.svh"

module lsu (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   rden_i,
    input  logic                   wren_i,
    input  logic [2:0]             memop_i,
    input  logic [`XLEN-1:0]       addr_i,
    input  logic [`XLEN-1:0]       st_data_i,
    input  ls_stage_pkg::mem_rsp_t mem_rsp_i,
    output ls_stage_pkg::mem_req_t mem_req_o,
    output logic [`XLEN-1:0]       ls_res_o,
    output logic                   load_valid_o
);

    logic [2:0]               byte_off;
    logic [5:0]               st_shift;
    logic [7:0]               st_mask;
    ls_stage_pkg::load_info_t ld_q;
    logic [5:0]               ld_shift;
    logic [`XLEN-1:0]         ld_lane;

    assign byte_off = addr_i[2:0];
    assign st_shift = {byte_off, 3'b000};

    // contiguous byte enables, accesses assumed aligned
    always_comb begin
        case (memop_i)
            `F3_B:   st_mask = 8'b0000_0001 << byte_off;
            `F3_H:   st_mask = 8'b0000_0011 << {byte_off[2:1], 1'b0};
            `F3_W:   st_mask = 8'b0000_1111 << {byte_off[2], 2'b00};
            `F3_D:   st_mask = 8'b1111_1111;
            default: st_mask = 8'b0000_0000;
        endcase
    end

    always_comb begin
        mem_req_o.en    = rden_i | wren_i;
        mem_req_o.we    = wren_i;
        mem_req_o.addr  = addr_i[`RAM_DEPTH_LOG2+2:3];
        // store data moved onto its byte lane
        mem_req_o.wdata = st_data_i << st_shift;
        mem_req_o.mask  = wren_i ? st_mask : 8'h00;
    end

    // remember width and offset until the ram data returns
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ld_q.valid <= 1'b0;
        end else begin
            ld_q.valid <= rden_i;
        end
        ld_q.funct3 <= memop_i;
        ld_q.offset <= byte_off;
    end

    assign ld_shift = {ld_q.offset, 3'b000};
    assign ld_lane  = mem_rsp_i.rdata >> ld_shift;

    // sign or zero extension by funct3
    always_comb begin
        case (ld_q.funct3)
            `F3_B:   ls_res_o = {{(`XLEN-8){ld_lane[7]}}, ld_lane[7:0]};
            `F3_H:   ls_res_o = {{(`XLEN-16){ld_lane[15]}}, ld_lane[15:0]};
            `F3_W:   ls_res_o = {{(`XLEN-32){ld_lane[31]}}, ld_lane[31:0]};
            `F3_BU:  ls_res_o = {{(`XLEN-8){1'b0}}, ld_lane[7:0]};
            `F3_HU:  ls_res_o = {{(`XLEN-16){1'b0}}, ld_lane[15:0]};
            `F3_WU:  ls_res_o = {{(`XLEN-32){1'b0}}, ld_lane[31:0]};
            default: ls_res_o = ld_lane;
        endcase
    end

    assign load_valid_o = ld_q.valid;

endmodule

/* ls_ctrl.sv */
`timescale 1ns/1ps
`include "ls_stage_macros.svh"

module ls_ctrl (
    input  ls_stage_pkg::instr_u instr_i,
    input  ls_stage_pkg::instr_u instr_last_i,
    input  logic [`XLEN-1:0]     rs2_i,
    input  logic [`XLEN-1:0]     wb_data_i,
    output logic                 rden_o,
    output logic                 wren_o,
    output logic                 csr_en_o,
    output logic [2:0]           memop_o,
    output logic [1:0]           csr_op_o,
    output logic [11:0]          csr_addr_o,
    output logic [`XLEN-1:0]     st_data_o
);

    logic is_load;
    logic is_store;
    logic is_system;
    logic last_is_load;
    logic fwd_hit;

    // full opcode match, low bits must be 2'b11
    assign is_load   = (instr_i.i.opcode == {`OP_LOAD, 2'b11});
    assign is_store  = (instr_i.s.opcode == {`OP_STORE, 2'b11});
    assign is_system = (instr_i.i.opcode == {`OP_SYSTEM, 2'b11});

    assign rden_o  = is_load;
    assign wren_o  = is_store;
    // width code sits in the same bits for loads and stores
    assign memop_o = instr_i.i.funct3;

    // only csrrw/csrrs/csrrc, immediate forms not handled
    assign csr_en_o   = is_system && !instr_i.i.funct3[2] && (instr_i.i.funct3[1:0] != 2'b00);
    assign csr_op_o   = instr_i.i.funct3[1:0];
    assign csr_addr_o = instr_i.i.imm;

    // load-to-store hazard on rs2
    assign last_is_load = (instr_last_i.i.opcode == {`OP_LOAD, 2'b11});
    assign fwd_hit      = last_is_load
                       && (instr_last_i.i.rd == instr_i.s.rs2)
                       && (instr_last_i.i.rd != 5'd0);

    assign st_data_o = fwd_hit ? wb_data_i : rs2_i;

endmodule

/* ls_stage_pkg.sv */
`include "ls_stage_macros.svh"

package ls_stage_pkg;

    // I-type view: loads and csr instructions
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    // S-type view: stores
    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } instr_s_t;

    // same instruction word, decoded either way
    typedef union packed {
        instr_i_t i;
        instr_s_t s;
    } instr_u;

    // one request on the single ram port
    typedef struct packed {
        logic                       en;
        logic                       we;
        logic [`RAM_DEPTH_LOG2-1:0] addr;
        logic [`XLEN-1:0]           wdata;
        logic [7:0]                 mask;
    } mem_req_t;

    // registered read data
    typedef struct packed {
        logic [`XLEN-1:0] rdata;
    } mem_rsp_t;

    // load in flight, from issue to result cycle
    typedef struct packed {
        logic       valid;
        logic [2:0] funct3;
        logic [2:0] offset;
    } load_info_t;

endpackage

/* ls_stage_macros.svh */
`ifndef LS_STAGE_MACROS_SVH
`define LS_STAGE_MACROS_SVH

// data path and instruction widths
`define XLEN            64
`define INST_LEN        32

// major opcodes, bits [6:2] of the instruction
`define OP_LOAD         5'b00000
`define OP_STORE        5'b01000
`define OP_SYSTEM       5'b11100

// load/store width codes (funct3)
`define F3_B            3'b000
`define F3_H            3'b001
`define F3_W            3'b010
`define F3_D            3'b011
`define F3_BU           3'b100
`define F3_HU           3'b101
`define F3_WU           3'b110

// csr operations (funct3 of SYSTEM)
`define F3_CSRRW        3'b001
`define F3_CSRRS        3'b010
`define F3_CSRRC        3'b011

// machine csr addresses
`define CSR_MSTATUS     12'h300
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

// environment call from M-mode
`define CAUSE_ECALL     11

// trap vector after reset
`define MTVEC_RESET     64'h0000_0000_8000_0000

// data ram geometry, in 64-bit words
`define RAM_DEPTH_LOG2  8
`define RAM_DEPTH       (1 << `RAM_DEPTH_LOG2)

`endif
